//--- wb_types_pkg.sv
// data widths, flag bit positions, register count and operand size codes
package wb_types_pkg;

   // data or address word
   typedef logic [31:0] word_t;

   // general register number, eax through edi
   typedef logic [2:0] reg_idx_t;

   // operand size as decoded
   typedef logic [1:0] datasize_t;

   // full eflags image
   typedef logic [31:0] flags_t;

   // one bit per writable flag
   // of in bit 6, then df, sf, zf, af, pf, cf in bit 0
   typedef logic [6:0] flag_mask_t;

   // byte lanes of a cache word
   typedef logic [3:0] byte_en_t;

   // operand size codes
   localparam datasize_t ds_byte  = 2'd0;
   localparam datasize_t ds_word  = 2'd1;
   localparam datasize_t ds_dword = 2'd2;

   // flag positions inside the eflags image
   localparam int flag_of = 11;
   localparam int flag_df = 10;
   localparam int flag_sf = 7;
   localparam int flag_zf = 6;
   localparam int flag_af = 4;
   localparam int flag_pf = 2;
   localparam int flag_cf = 0;

   localparam int gpr_count = 8;

   // bit 1 of eflags always reads as one
   localparam flags_t flags_reset_value = 32'h0000_0002;

endpackage

//--- wb_ctrl_pkg.sv
// control-store word, writeback latch, validated strobes and cmps phase enum
package wb_ctrl_pkg;

   import wb_types_pkg::*;

   // control-store word, only the low six bits are used here
   typedef struct packed {
      logic [57:0] reserved;
      logic        ld_flags;
      logic        ld_gpr3;
      logic        ld_gpr2;
      logic        is_first_of_repne;
      logic        is_cmps_second;
      logic        is_cmps_first;
   } cs_word_t;

   // contents of the writeback latch
   typedef struct packed {
      logic       v;
      cs_word_t   cs;
      // hints generated in decode
      datasize_t  datasize;
      logic       ld_gpr1;
      logic       dcache_write;
      flag_mask_t flags_affected;
      // results from execute
      word_t      alu_result;
      word_t      pointer;
      word_t      count;
      word_t      address;
      flags_t     new_flags;
      reg_idx_t   dr1;
      reg_idx_t   dr2;
      reg_idx_t   dr3;
   } wb_latch_t;

   // every strobe already qualified by v
   typedef struct packed {
      logic we1;
      logic we2;
      logic we3;
      logic ld_flags;
      logic store;
      logic cmps_first;
      logic cmps_second;
      logic repne_step;
   } wb_strobes_t;

   typedef enum logic {
      phase_normal,
      phase_cmps_pending
   } wb_phase_t;

endpackage

//--- wb_control.sv
// writeback control: control-store unpack, strobe validation, cmps micro-op phase
`timescale 1ns/1ns

module wb_control import wb_ctrl_pkg::*; (
   input  logic        CLK,
   input  logic        arst_n,
   input  wb_latch_t   wb_in,
   output wb_strobes_t strobes,
   output wb_phase_t   phase
);

   cs_word_t  cs;
   wb_phase_t phase_nxt;
   logic      second_in_pair;

   assign cs = wb_in.cs;

   // a second uop only counts when a first one is outstanding
   assign second_in_pair = (phase == phase_cmps_pending);

   // qualify every write with the valid bit
   always_comb begin
      strobes.we1         = wb_in.v & wb_in.ld_gpr1;
      strobes.we2         = wb_in.v & cs.ld_gpr2;
      strobes.we3         = wb_in.v & cs.ld_gpr3;
      strobes.ld_flags    = wb_in.v & cs.ld_flags;
      strobes.store       = wb_in.v & wb_in.dcache_write;
      strobes.cmps_first  = wb_in.v & cs.is_cmps_first;
      strobes.cmps_second = wb_in.v & cs.is_cmps_second & second_in_pair;
      strobes.repne_step  = wb_in.v & cs.is_first_of_repne;
   end

   // first uop opens the pair, second closes it
   always_comb begin
      phase_nxt = phase;
      if (strobes.cmps_first) begin
         phase_nxt = phase_cmps_pending;
      end else if (strobes.cmps_second) begin
         phase_nxt = phase_normal;
      end
   end

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         phase <= phase_normal;
      end else begin
         phase <= phase_nxt;
      end
   end

endmodule

//--- cmps_pointer_unit.sv
// string pointer stepping by operand size and direction, saved first-uop pointer
`timescale 1ns/1ns

module cmps_pointer_unit import wb_types_pkg::*; (
   input  logic      CLK,
   input  logic      arst_n,
   input  word_t     pointer,
   input  datasize_t datasize,
   input  logic      df,
   input  logic      capture,
   output word_t     step_pointer,
   output word_t     saved_pointer
);

   word_t step_size;

   // bytes moved per element
   always_comb begin
      case (datasize)
         ds_byte:  step_size = 32'd1;
         ds_word:  step_size = 32'd2;
         ds_dword: step_size = 32'd4;
         default:  step_size = 32'd4;
      endcase
   end

   // df set walks the string downwards
   assign step_pointer = df ? (pointer - step_size) : (pointer + step_size);

   // first cmps uop parks its advanced source pointer here
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         saved_pointer <= '0;
      end else if (capture) begin
         saved_pointer <= step_pointer;
      end
   end

endmodule

//--- flags_unit.sv
// architectural flags register with per-flag masked update
`timescale 1ns/1ns

module flags_unit import wb_types_pkg::*; (
   input  logic       CLK,
   input  logic       arst_n,
   input  logic       ld_flags,
   input  flag_mask_t affected,
   input  flags_t     new_flags,
   output flags_t     flags
);

   flags_t wr_mask;
   flags_t flags_nxt;

   // spread the 7-bit mask onto eflags positions
   always_comb begin
      wr_mask          = '0;
      wr_mask[flag_of] = affected[6];
      wr_mask[flag_df] = affected[5];
      wr_mask[flag_sf] = affected[4];
      wr_mask[flag_zf] = affected[3];
      wr_mask[flag_af] = affected[2];
      wr_mask[flag_pf] = affected[1];
      wr_mask[flag_cf] = affected[0];
   end

   // untouched flags keep their value, bit 1 forced high
   assign flags_nxt = (flags & ~wr_mask) | (new_flags & wr_mask) | flags_reset_value;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         flags <= flags_reset_value;
      end else if (ld_flags) begin
         flags <= flags_nxt;
      end
   end

endmodule

//--- repne_count_unit.sv
// repne count decrement and termination detect
`timescale 1ns/1ns

module repne_count_unit import wb_types_pkg::*; (
   input  word_t count,
   input  logic  repne_step,
   input  logic  zf,
   output word_t next_count,
   output logic  repne_done
);

   logic count_exhausted;

   // ecx after this iteration
   assign next_count = count - 32'd1;

   assign count_exhausted = (next_count == '0);

   // stop on last iteration or on a compare match
   assign repne_done = repne_step & (count_exhausted | zf);

endmodule

//--- wb_route.sv
// destination data select and byte-aligned data cache store formation
`timescale 1ns/1ns

module wb_route import wb_types_pkg::*, wb_ctrl_pkg::*; (
   input  wb_strobes_t strobes,
   input  word_t       alu_result,
   input  word_t       saved_pointer,
   input  word_t       step_pointer,
   input  word_t       next_count,
   input  word_t       address,
   input  datasize_t   datasize,
   output word_t       wdata1,
   output word_t       wdata2,
   output word_t       wdata3,
   output logic        dcache_we,
   output word_t       dcache_addr,
   output word_t       dcache_data,
   output byte_en_t    dcache_be
);

   byte_en_t size_be;
   logic [4:0] lane_shift;

   // second cmps uop retires the pointer saved by the first
   assign wdata1 = strobes.cmps_second ? saved_pointer : alu_result;
   assign wdata2 = step_pointer;
   assign wdata3 = next_count;

   // lanes touched by an aligned operand
   always_comb begin
      case (datasize)
         ds_byte:  size_be = 4'b0001;
         ds_word:  size_be = 4'b0011;
         ds_dword: size_be = 4'b1111;
         default:  size_be = 4'b1111;
      endcase
   end

   assign lane_shift = {address[1:0], 3'b000};

   assign dcache_we   = strobes.store;
   assign dcache_addr = {address[31:2], 2'b00};
   assign dcache_data = wdata1 << lane_shift;
   assign dcache_be   = size_be << address[1:0];

endmodule

//--- gpr_file.sv
// eight general registers, three prioritized write ports, one read port
`timescale 1ns/1ns

module gpr_file import wb_types_pkg::*; (
   input  logic     CLK,
   input  logic     arst_n,
   input  logic     we1,
   input  logic     we2,
   input  logic     we3,
   input  reg_idx_t dr1,
   input  reg_idx_t dr2,
   input  reg_idx_t dr3,
   input  word_t    wdata1,
   input  word_t    wdata2,
   input  word_t    wdata3,
   input  reg_idx_t rd_idx,
   output word_t    rd_data
);

   word_t regs [gpr_count];

   // later ports override earlier ones on the same index
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < gpr_count; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (we1) begin
            regs[dr1] <= wdata1;
         end
         if (we2) begin
            regs[dr2] <= wdata2;
         end
         if (we3) begin
            regs[dr3] <= wdata3;
         end
      end
   end

   assign rd_data = regs[rd_idx];

endmodule

//--- wb_subsystem.sv
// writeback stage top: control, pointer, flags, repne, routing and register file
`timescale 1ns/1ns

module wb_subsystem import wb_types_pkg::*, wb_ctrl_pkg::*; (
   input  logic      CLK,
   input  logic      arst_n,
   input  wb_latch_t wb_in,
   input  reg_idx_t  rd_idx,
   output word_t     rd_data,
   output flags_t    flags,
   output logic      repne_done,
   output logic      dcache_we,
   output word_t     dcache_addr,
   output word_t     dcache_data,
   output byte_en_t  dcache_be
);

   wb_strobes_t strobes;
   word_t       step_pointer;
   word_t       saved_pointer;
   word_t       next_count;
   word_t       wdata1;
   word_t       wdata2;
   word_t       wdata3;

   wb_control u_control (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .wb_in   (wb_in),
      .strobes (strobes),
      .phase   ()
   );

   cmps_pointer_unit u_pointer (
      .CLK           (CLK),
      .arst_n        (arst_n),
      .pointer       (wb_in.pointer),
      .datasize      (wb_in.datasize),
      .df            (flags[flag_df]),
      .capture       (strobes.cmps_first),
      .step_pointer  (step_pointer),
      .saved_pointer (saved_pointer)
   );

   flags_unit u_flags (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .ld_flags  (strobes.ld_flags),
      .affected  (wb_in.flags_affected),
      .new_flags (wb_in.new_flags),
      .flags     (flags)
   );

   // zf here is the flag before this row's update
   repne_count_unit u_repne (
      .count      (wb_in.count),
      .repne_step (strobes.repne_step),
      .zf         (flags[flag_zf]),
      .next_count (next_count),
      .repne_done (repne_done)
   );

   wb_route u_route (
      .strobes       (strobes),
      .alu_result    (wb_in.alu_result),
      .saved_pointer (saved_pointer),
      .step_pointer  (step_pointer),
      .next_count    (next_count),
      .address       (wb_in.address),
      .datasize      (wb_in.datasize),
      .wdata1        (wdata1),
      .wdata2        (wdata2),
      .wdata3        (wdata3),
      .dcache_we     (dcache_we),
      .dcache_addr   (dcache_addr),
      .dcache_data   (dcache_data),
      .dcache_be     (dcache_be)
   );

   gpr_file u_gpr (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .we1     (strobes.we1),
      .we2     (strobes.we2),
      .we3     (strobes.we3),
      .dr1     (wb_in.dr1),
      .dr2     (wb_in.dr2),
      .dr3     (wb_in.dr3),
      .wdata1  (wdata1),
      .wdata2  (wdata2),
      .wdata3  (wdata3),
      .rd_idx  (rd_idx),
      .rd_data (rd_data)
   );

endmodule

//--- tb_wb_vectors.svh
// writeback vector table: latch stimulus rows, readback index and expected outputs
`ifndef tb_wb_vectors_svh
`define tb_wb_vectors_svh

   // readback index and expected outputs for one row
   typedef struct packed {
      reg_idx_t rd_idx;
      word_t    rd_data;
      flags_t   flags;
      logic     done;
      logic     we;
      word_t    addr;
      word_t    data;
      byte_en_t be;
   } check_t;

   localparam int n_rows = 13;

   // v, cs, datasize, ld_gpr1, dcache_write, flags_affected, alu_result, pointer,
   // count, address, new_flags, dr1, dr2, dr3
   localparam wb_latch_t latch_tab [n_rows] = '{
      '{1'b1, 64'h00, ds_dword, 1'b1, 1'b0, 7'h00, 32'h1111_1111, 32'h0000_0000,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 3'd1, 3'd0, 3'd0},
      // invalid row with every write enabled
      '{1'b0, 64'h3c, ds_dword, 1'b1, 1'b1, 7'h7f, 32'hdead_beef, 32'h0000_0000,
        32'h0000_0001, 32'h0000_0004, 32'hffff_ffff, 3'd1, 3'd1, 3'd1},
      '{1'b1, 64'h18, ds_dword, 1'b1, 1'b0, 7'h00, 32'haaaa_0001, 32'h0000_0100,
        32'h0000_0005, 32'h0000_0000, 32'h0000_0000, 3'd2, 3'd2, 3'd2},
      // sets df, zf and cf
      '{1'b1, 64'h28, ds_byte, 1'b1, 1'b0, 7'h29, 32'h5555_5555, 32'h0000_0200,
        32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 3'd3, 3'd3, 3'd0},
      '{1'b1, 64'h08, ds_word, 1'b0, 1'b0, 7'h00, 32'h0000_0000, 32'h0000_1000,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 3'd0, 3'd4, 3'd0},
      '{1'b1, 64'h1c, ds_dword, 1'b0, 1'b0, 7'h00, 32'h0000_0000, 32'h0000_1000,
        32'h0000_000a, 32'h0000_0000, 32'h0000_0000, 3'd0, 3'd3, 3'd5},
      // clears df and zf, cf stays
      '{1'b1, 64'h28, ds_byte, 1'b0, 1'b0, 7'h28, 32'h0000_0000, 32'h0000_1000,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 3'd0, 3'd4, 3'd0},
      '{1'b1, 64'h14, ds_dword, 1'b0, 1'b0, 7'h00, 32'h0000_0000, 32'h0000_0000,
        32'h0000_000a, 32'h0000_0000, 32'h0000_0000, 3'd0, 3'd0, 3'd6},
      // last repne step, also the first cmps uop
      '{1'b1, 64'h15, ds_dword, 1'b0, 1'b0, 7'h00, 32'h0000_0000, 32'h0000_3000,
        32'h0000_0001, 32'h0000_0000, 32'h0000_0000, 3'd0, 3'd0, 3'd5},
      '{1'b1, 64'h0a, ds_dword, 1'b1, 1'b0, 7'h00, 32'h7777_7777, 32'h0000_4000,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 3'd7, 3'd0, 3'd0},
      // lone second uop, then stores of each size
      '{1'b1, 64'h02, ds_byte, 1'b1, 1'b1, 7'h00, 32'h1234_56a5, 32'h0000_0000,
        32'h0000_0000, 32'h0000_2003, 32'h0000_0000, 3'd1, 3'd0, 3'd0},
      '{1'b1, 64'h00, ds_word, 1'b0, 1'b1, 7'h00, 32'h0000_beef, 32'h0000_0000,
        32'h0000_0000, 32'h0000_2006, 32'h0000_0000, 3'd0, 3'd0, 3'd0},
      '{1'b1, 64'h00, ds_dword, 1'b0, 1'b1, 7'h00, 32'hcafe_f00d, 32'h0000_0000,
        32'h0000_0000, 32'h0000_2008, 32'h0000_0000, 3'd0, 3'd0, 3'd0}
   };

   // rd_idx, rd_data and flags after the edge, then repne_done and the cache port
   localparam check_t check_tab [n_rows] = '{
      '{3'd1, 32'h1111_1111, 32'h0000_0002, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd1, 32'h1111_1111, 32'h0000_0002, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd2, 32'h0000_0004, 32'h0000_0002, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd3, 32'h0000_0201, 32'h0000_0443, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd4, 32'h0000_0ffe, 32'h0000_0443, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd5, 32'h0000_0009, 32'h0000_0443, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd3, 32'h0000_0ffc, 32'h0000_0003, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd4, 32'h0000_0fff, 32'h0000_0003, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd6, 32'h0000_0009, 32'h0000_0003, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd7, 32'h0000_3004, 32'h0000_0003, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0},
      '{3'd0, 32'h0000_4004, 32'h0000_0003, 1'b0, 1'b1, 32'h0000_2000, 32'ha500_0000, 4'h8},
      '{3'd1, 32'h1234_56a5, 32'h0000_0003, 1'b0, 1'b1, 32'h0000_2004, 32'hbeef_0000, 4'hc},
      '{3'd2, 32'h0000_0004, 32'h0000_0003, 1'b0, 1'b1, 32'h0000_2008, 32'hcafe_f00d, 4'hf}
   };

`endif

//--- tb_wb_subsystem.sv
// writeback stage testbench: clock, reset, vector table, random rows and reference model
`timescale 1ns/1ns

module tb_wb_subsystem import wb_types_pkg::*, wb_ctrl_pkg::*; ();

   `include "tb_wb_vectors.svh"

   localparam int n_random   = 40;
   localparam int max_cycles = (n_rows + n_random) * 2 + 20;

   logic      CLK;
   logic      arst_n;
   wb_latch_t wb_in;
   reg_idx_t  rd_idx;
   word_t     rd_data;
   flags_t    flags;
   logic      repne_done;
   logic      dcache_we;
   word_t     dcache_addr;
   word_t     dcache_data;
   byte_en_t  dcache_be;

   // reference model state
   word_t     m_regs [gpr_count];
   flags_t    m_flags;
   word_t     m_saved;
   logic      m_pending;

   word_t     rng;
   int        cycles;
   wb_latch_t rnd_latch;
   reg_idx_t  rnd_rd;
   check_t    exp_row;

   wb_subsystem dut0 (.*);

   initial CLK = 1'b0;
   always #20 CLK = ~CLK;

   function automatic word_t xorshift(input word_t x);
      word_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         $display("Some tests failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // expected outputs of one row, model state moves on by one cycle
   task automatic model_row(input wb_latch_t s, input reg_idx_t rd, output check_t e);
      word_t    size;
      word_t    step;
      word_t    wdata1;
      byte_en_t be;
      logic     second;
      int       pos [7] = '{flag_cf, flag_pf, flag_af, flag_zf, flag_sf, flag_df, flag_of};
      size   = (s.datasize == ds_byte) ? 32'd1 : (s.datasize == ds_word) ? 32'd2 : 32'd4;
      be     = (s.datasize == ds_byte) ? 4'h1 : (s.datasize == ds_word) ? 4'h3 : 4'hf;
      step   = m_flags[flag_df] ? (s.pointer - size) : (s.pointer + size);
      second = s.v & s.cs.is_cmps_second & m_pending;
      wdata1 = second ? m_saved : s.alu_result;
      e.rd_idx = rd;
      e.done   = s.v & s.cs.is_first_of_repne
               & (((s.count - 32'd1) == 32'd0) | m_flags[flag_zf]);
      e.we     = s.v & s.dcache_write;
      e.addr   = {s.address[31:2], 2'b00};
      e.data   = wdata1 << {s.address[1:0], 3'b000};
      e.be     = be << s.address[1:0];
      if (s.v) begin
         // port 3 written last so it wins
         if (s.ld_gpr1)
            m_regs[s.dr1] = wdata1;
         if (s.cs.ld_gpr2)
            m_regs[s.dr2] = step;
         if (s.cs.ld_gpr3)
            m_regs[s.dr3] = s.count - 32'd1;
         if (s.cs.ld_flags) begin
            for (int i = 0; i < 7; i++) begin
               if (s.flags_affected[i])
                  m_flags[pos[i]] = s.new_flags[pos[i]];
            end
         end
         if (s.cs.is_cmps_first) begin
            m_saved   = step;
            m_pending = 1'b1;
         end else if (second) begin
            m_pending = 1'b0;
         end
      end
      e.rd_data = m_regs[rd];
      e.flags   = m_flags;
   endtask

   task automatic random_row(output wb_latch_t s, output reg_idx_t rd);
      word_t r;
      r = next_rand();
      s = '0;
      // valid most of the time
      s.v              = (r[3:0] != 4'd0);
      s.cs             = {58'd0, r[9:4]};
      s.ld_gpr1        = r[10];
      s.dcache_write   = r[11];
      s.datasize       = (r[13:12] == 2'd3) ? ds_dword : r[13:12];
      s.flags_affected = r[20:14];
      s.dr1            = r[23:21];
      s.dr2            = r[26:24];
      s.dr3            = r[29:27];
      r = next_rand();
      // small counts so the last repne step comes up
      s.count      = {29'd0, r[2:0]};
      rd           = r[5:3];
      s.alu_result = next_rand();
      s.pointer    = next_rand();
      s.address    = next_rand();
      s.new_flags  = next_rand();
   endtask

   // called on a falling edge, returns on the next one
   task automatic apply_row(input wb_latch_t s, input check_t e);
      wb_in  = s;
      rd_idx = e.rd_idx;
      #5;
      check_value("repne_done", 32'(repne_done), 32'(e.done));
      check_value("dcache_we", 32'(dcache_we), 32'(e.we));
      if (e.we) begin
         check_value("dcache_addr", dcache_addr, e.addr);
         check_value("dcache_data", dcache_data, e.data);
         check_value("dcache_be", 32'(dcache_be), 32'(e.be));
      end
      @(negedge CLK);
      check_value("rd_data", rd_data, e.rd_data);
      check_value("flags", flags, e.flags);
   endtask

   initial begin
      rng       = 32'd13;
      m_flags   = flags_reset_value;
      m_saved   = '0;
      m_pending = 1'b0;
      for (int i = 0; i < gpr_count; i++) begin
         m_regs[i] = '0;
      end
      wb_in  = '0;
      rd_idx = '0;
      arst_n = 1'b0;
      repeat (5) @(negedge CLK);
      arst_n = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         model_row(latch_tab[i], check_tab[i].rd_idx, exp_row);
         apply_row(latch_tab[i], check_tab[i]);
      end
      for (int i = 0; i < n_random; i++) begin
         random_row(rnd_latch, rnd_rd);
         model_row(rnd_latch, rnd_rd, exp_row);
         apply_row(rnd_latch, exp_row);
      end
      $display("All tests passed");
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge CLK);
         cycles++;
      end
      $display("simulation timed out after %0d cycles", cycles);
      $display("Some tests failed");
      $fatal(1, "timeout");
   end

endmodule

//--- build.f
+incdir+.
wb_types_pkg.sv
wb_ctrl_pkg.sv
wb_control.sv
cmps_pointer_unit.sv
flags_unit.sv
repne_count_unit.sv
wb_route.sv
gpr_file.sv
wb_subsystem.sv
tb_wb_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

verilator --binary --timing -f build.f --top-module tb_wb_subsystem -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -qx "All tests passed"; then
   exit 0
fi
exit 1
